/* filelist.f */
rtl/cdb_pkg.sv
rtl/eu_result_fifo.sv
rtl/cdb_arbiter.sv
rtl/cdb.sv
rtl/cdb_subsys.sv
tb/tb_cdb_subsys.sv

/* rtl/cdb.sv */
// Common data bus, arbitration plus the output data multiplexer
`timescale 1ns/1ps
`default_nettype none

module cdb (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  input  logic                                               flush_i,

  // Max-priority unit
  input  logic                                               max_prio_valid_i,
  output logic                                               max_prio_ready_o,
  input  cdb_pkg::cdb_data_t                                 max_prio_data_i,

  // Low-priority units
  input  logic               [cdb_pkg::LOW_EU_N-1:0]         rs_valid_i,
  output logic               [cdb_pkg::LOW_EU_N-1:0]         rs_ready_o,
  input  cdb_pkg::cdb_data_t [cdb_pkg::LOW_EU_N-1:0]         rs_data_i,

  // ROB side and broadcast
  input  logic                                               rob_ready_i,
  output logic                                               valid_o,
  output cdb_pkg::cdb_data_t                                 data_o
);

  // Output of the low-priority mux
  cdb_pkg::cdb_data_t  low_prio_data;

  // Served unit from the arbiter
  logic                served_max_prio;
  cdb_pkg::eu_idx_t    served;

  // -------------------------------------------------------------------------
  // Arbitration
  // -------------------------------------------------------------------------

  cdb_arbiter i_cdb_arbiter (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .flush_i           (flush_i),
    .max_prio_valid_i  (max_prio_valid_i),
    .max_prio_ready_o  (max_prio_ready_o),
    .valid_i           (rs_valid_i),
    .ready_o           (rs_ready_o),
    .rob_ready_i       (rob_ready_i),
    .rob_valid_o       (valid_o),
    .served_max_prio_o (served_max_prio),
    .served_o          (served)
  );

  // -------------------------------------------------------------------------
  // Output mux
  // -------------------------------------------------------------------------

  // Pick the round-robin winner first
  assign low_prio_data = rs_data_i[served];

  // Max-priority head overrides it
  assign data_o = served_max_prio ? max_prio_data_i : low_prio_data;

endmodule

`default_nettype wire

/* rtl/cdb_arbiter.sv */
// CDB arbiter, fixed priority for unit 0 and round-robin among the others
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,

  // Max-priority unit handshake
  input  logic                          max_prio_valid_i,
  output logic                          max_prio_ready_o,

  // Low-priority unit handshakes, bit 0 is unit 1
  input  logic [cdb_pkg::LOW_EU_N-1:0]  valid_i,
  output logic [cdb_pkg::LOW_EU_N-1:0]  ready_o,

  // ROB handshake
  input  logic                          rob_ready_i,
  output logic                          rob_valid_o,

  // Served unit, steers the data mux
  output logic                          served_max_prio_o,
  output cdb_pkg::eu_idx_t              served_o
);

  // Round-robin pointer, first unit looked at in the search
  cdb_pkg::eu_idx_t  rr_ptr;

  // Search result
  cdb_pkg::eu_idx_t  low_sel;
  logic              low_found;

  // A low-priority head wins the bus and the ROB takes it
  logic              low_xfer;

  // -------------------------------------------------------------------------
  // Helper
  // -------------------------------------------------------------------------

  // Next low-priority unit, wrapping after the last one
  function automatic cdb_pkg::eu_idx_t next_idx(input cdb_pkg::eu_idx_t idx);
    if (idx == cdb_pkg::eu_idx_t'(cdb_pkg::LOW_EU_N - 1)) begin
      return '0;
    end
    return idx + cdb_pkg::eu_idx_t'(1);
  endfunction

  // -------------------------------------------------------------------------
  // Wrapping priority search
  // -------------------------------------------------------------------------

  // Walk from the pointer upward, keep the first valid unit
  always_comb begin
    cdb_pkg::eu_idx_t cand;
    cand      = rr_ptr;
    low_sel   = rr_ptr;
    low_found = 1'b0;
    for (int unsigned i = 0; i < cdb_pkg::LOW_EU_N; i++) begin
      if (!low_found && valid_i[cand]) begin
        low_sel   = cand;
        low_found = 1'b1;
      end
      cand = next_idx(cand);
    end
  end

  // -------------------------------------------------------------------------
  // Grant and handshake outputs
  // -------------------------------------------------------------------------

  // Unit 0 always preempts the rotation
  assign served_max_prio_o = max_prio_valid_i;
  assign served_o          = low_sel;

  // Something is on the bus whenever any head is valid
  assign rob_valid_o = max_prio_valid_i | low_found;

  // Readies only for the served unit, and only when the ROB accepts
  assign max_prio_ready_o = max_prio_valid_i & rob_ready_i;
  assign low_xfer         = ~max_prio_valid_i & low_found & rob_ready_i;

  // One-hot ready towards the low-priority buffers
  always_comb begin
    ready_o = '0;
    if (low_xfer) begin
      ready_o[low_sel] = 1'b1;
    end
  end

  // -------------------------------------------------------------------------
  // Pointer update
  // -------------------------------------------------------------------------

  // Moves past the served unit on low-priority transfers only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      rr_ptr <= '0;  // back to unit 1
    end else if (low_xfer) begin
      rr_ptr <= next_idx(low_sel);
    end
  end

endmodule

`default_nettype wire

/* rtl/cdb_pkg.sv */
// CDB package with the shared widths, result types and bus item format
`default_nettype none

package cdb_pkg;

  // -------------------------------------------------------------------------
  // Datapath widths
  // -------------------------------------------------------------------------

  // Width of one result value
  localparam int unsigned XLEN = 32;

  // Reorder-buffer index width, 16 ROB entries
  localparam int unsigned ROB_IDX_W = 4;

  // -------------------------------------------------------------------------
  // Execution unit count
  // -------------------------------------------------------------------------

  // All units on the bus, unit 0 is the max-priority one
  localparam int unsigned MAX_EU_N = 4;

  // Units that share the round-robin slots
  localparam int unsigned LOW_EU_N = MAX_EU_N - 1;

  // Enough bits to number every low-priority unit
  localparam int unsigned EU_IDX_W = 2;

  // -------------------------------------------------------------------------
  // Result buffer geometry
  // -------------------------------------------------------------------------

  // Entries held in front of each unit
  localparam int unsigned FIFO_DEPTH = 2;

  // Occupancy counter, must reach FIFO_DEPTH itself
  localparam int unsigned FIFO_CNT_W = 2;

  // Read and write pointer width, never below one bit
  localparam int unsigned FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // -------------------------------------------------------------------------
  // Types
  // -------------------------------------------------------------------------

  // Result value
  typedef logic [XLEN-1:0] value_t;

  // Destination tag in the ROB
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // Low-priority unit number, 0 stands for unit 1
  typedef logic [EU_IDX_W-1:0] eu_idx_t;

  // Buffer occupancy and buffer slot
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

  // Item broadcast on the bus, 37 bits wide
  typedef struct packed {
    rob_idx_t rob_idx;
    value_t   value;
    logic     except;
  } cdb_data_t;

endpackage

`default_nettype wire

/* rtl/cdb_subsys.sv */
// Write-back subsystem, one result buffer per execution unit feeding the CDB
`timescale 1ns/1ps
`default_nettype none

module cdb_subsys (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                                       flush_i,

  // Execution unit results, index 0 is the max-priority unit
  input  logic               [cdb_pkg::MAX_EU_N-1:0] eu_valid_i,
  output logic               [cdb_pkg::MAX_EU_N-1:0] eu_ready_o,
  input  cdb_pkg::cdb_data_t [cdb_pkg::MAX_EU_N-1:0] eu_data_i,

  // ROB handshake and bus broadcast
  input  logic                                       rob_ready_i,
  output logic                                       valid_o,
  output cdb_pkg::cdb_data_t                         data_o
);

  // -------------------------------------------------------------------------
  // Buffer heads
  // -------------------------------------------------------------------------

  // Head valid per unit
  logic               [cdb_pkg::MAX_EU_N-1:0] head_valid;

  // Pop strobe per unit, driven by the bus
  logic               [cdb_pkg::MAX_EU_N-1:0] head_ready;

  // Head item per unit
  cdb_pkg::cdb_data_t [cdb_pkg::MAX_EU_N-1:0] head_data;

  // -------------------------------------------------------------------------
  // Result buffers
  // -------------------------------------------------------------------------

  // Same buffer in front of every unit, max-priority one included
  for (genvar k = 0; k < cdb_pkg::MAX_EU_N; k++) begin : gen_eu_fifo
    eu_result_fifo i_eu_result_fifo (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .flush_i      (flush_i),
      .push_valid_i (eu_valid_i[k]),
      .push_data_i  (eu_data_i[k]),
      .push_ready_o (eu_ready_o[k]),
      .pop_valid_o  (head_valid[k]),
      .pop_data_o   (head_data[k]),
      .pop_ready_i  (head_ready[k])
    );
  end

  // -------------------------------------------------------------------------
  // Common data bus
  // -------------------------------------------------------------------------

  // Unit 0 goes to the max-priority port
  // Units 1 and up map onto the round-robin vector from bit 0
  cdb i_cdb (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .max_prio_valid_i (head_valid[0]),
    .max_prio_ready_o (head_ready[0]),
    .max_prio_data_i  (head_data[0]),
    .rs_valid_i       (head_valid[cdb_pkg::MAX_EU_N-1:1]),
    .rs_ready_o       (head_ready[cdb_pkg::MAX_EU_N-1:1]),
    .rs_data_i        (head_data[cdb_pkg::MAX_EU_N-1:1]),
    .rob_ready_i      (rob_ready_i),
    .valid_o          (valid_o),
    .data_o           (data_o)
  );

endmodule

`default_nettype wire

/* rtl/eu_result_fifo.sv */
// Result buffer that decouples one execution unit from the common data bus
`timescale 1ns/1ps
`default_nettype none

module eu_result_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,

  // Write side, from the execution unit
  input  logic                push_valid_i,
  input  cdb_pkg::cdb_data_t  push_data_i,
  output logic                push_ready_o,

  // Read side, towards the bus
  output logic                pop_valid_o,
  output cdb_pkg::cdb_data_t  pop_data_o,
  input  logic                pop_ready_i
);

  // Storage, payload only
  cdb_pkg::cdb_data_t  mem [cdb_pkg::FIFO_DEPTH];

  // Control state
  cdb_pkg::fifo_ptr_t  wr_ptr;
  cdb_pkg::fifo_ptr_t  rd_ptr;
  cdb_pkg::fifo_cnt_t  count;

  // Handshake qualifiers
  logic                full;
  logic                empty;
  logic                push_en;
  logic                pop_en;

  // -------------------------------------------------------------------------
  // Status and handshake
  // -------------------------------------------------------------------------

  assign full  = (count == cdb_pkg::fifo_cnt_t'(cdb_pkg::FIFO_DEPTH));
  assign empty = (count == '0);

  // Accept new results whenever a slot is free
  assign push_ready_o = ~full;
  assign push_en      = push_valid_i & ~full;

  // Head leaves when the bus grants it
  assign pop_valid_o = ~empty;
  assign pop_en      = pop_ready_i & ~empty;

  // Head of the buffer goes straight to the bus mux
  assign pop_data_o = mem[rd_ptr];

  // -------------------------------------------------------------------------
  // Storage write
  // -------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // -------------------------------------------------------------------------
  // Pointers and occupancy
  // -------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      // Flush drops everything, including a push in the same cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap explicitly so a depth that is not a power of two still works
      if (push_en) begin
        if (wr_ptr == cdb_pkg::fifo_ptr_t'(cdb_pkg::FIFO_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + cdb_pkg::fifo_ptr_t'(1);
        end
      end
      if (pop_en) begin
        if (rd_ptr == cdb_pkg::fifo_ptr_t'(cdb_pkg::FIFO_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + cdb_pkg::fifo_ptr_t'(1);
        end
      end
      // Push and pop together leave the count alone
      case ({push_en, pop_en})
        2'b10:   count <= count + cdb_pkg::fifo_cnt_t'(1);
        2'b01:   count <= count - cdb_pkg::fifo_cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the CDB testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
  --top-module tb_cdb_subsys -o tb_cdb_subsys > "$BUILD_LOG" 2>&1 \
  || { echo "Verilator build failed, see $BUILD_LOG"; exit 1; }

./obj_dir/tb_cdb_subsys > "$SIM_LOG" 2>&1 \
  || { echo "Simulation exited with an error, see $SIM_LOG"; exit 1; }

grep -q "Simulation FAILED" "$SIM_LOG" \
  && { echo "Failure reported, see $SIM_LOG"; exit 1; }

echo "No failure reported, log in $SIM_LOG"
exit 0

/* tb/tb_cdb_subsys.sv */
// Testbench for the CDB write-back subsystem, random traffic checked against a queue model
`timescale 1ns/1ps
`default_nettype none

module tb_cdb_subsys;

  // --------------------------------------------------------------------------
  // Run parameters
  // --------------------------------------------------------------------------

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned DRIVE_DLY    = 1;
  localparam int unsigned RESET_CYCLES = 4;
  localparam int unsigned SEED         = 14966;

  // Phase lengths in cycles
  localparam int unsigned MIX_CYCLES   = 400;
  localparam int unsigned PRIO_CYCLES  = 200;
  localparam int unsigned STALL_CYCLES = 20;
  localparam int unsigned DRAIN_CYCLES = 40;
  localparam int unsigned LOAD_CYCLES  = 30;
  localparam int unsigned ROT_CYCLES   = 60;

  // Reset, the post-reset check cycle and the single flush cycle included
  localparam int unsigned TOTAL_CYCLES = RESET_CYCLES + 1 + MIX_CYCLES + PRIO_CYCLES
                                       + STALL_CYCLES + DRAIN_CYCLES + LOAD_CYCLES + 1
                                       + ROT_CYCLES + DRAIN_CYCLES;
  localparam int unsigned MARGIN_CYCLES = 100;

  // --------------------------------------------------------------------------
  // DUT signals
  // --------------------------------------------------------------------------

  logic                                       clk_i;
  logic                                       rst_n_i;
  logic                                       flush_i;
  logic               [cdb_pkg::MAX_EU_N-1:0] eu_valid_i;
  logic               [cdb_pkg::MAX_EU_N-1:0] eu_ready_o;
  cdb_pkg::cdb_data_t [cdb_pkg::MAX_EU_N-1:0] eu_data_i;
  logic                                       rob_ready_i;
  logic                                       valid_o;
  cdb_pkg::cdb_data_t                         data_o;

  // --------------------------------------------------------------------------
  // Model state and counters
  // --------------------------------------------------------------------------

  // One queue per unit, mirrors the result buffers
  cdb_pkg::cdb_data_t model_q [cdb_pkg::MAX_EU_N][$];

  // Round-robin pointer, 0 stands for unit 1
  int unsigned model_ptr;
  // Unit number expected next while all low-priority units are loaded
  int unsigned rot_expect;
  bit          flush_pending;

  int          errors;
  int          checks;
  int          transfers;
  int          tag_ctr;

  cdb_subsys i_cdb_subsys (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .eu_valid_i  (eu_valid_i),
    .eu_ready_o  (eu_ready_o),
    .eu_data_i   (eu_data_i),
    .rob_ready_i (rob_ready_i),
    .valid_o     (valid_o),
    .data_o      (data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Compare one value and log a mismatch
  task automatic check_val(input string name, input logic [63:0] exp_val,
                           input logic [63:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("FAILED %s: expected 0x%0h, actual 0x%0h at %0t", name, exp_val, act_val, $time);
    end
  endtask

  // One clock cycle: drive after the edge, check mid-cycle, update the model
  task automatic step(input string name, input int unsigned p_max, input int unsigned p_low,
                      input int unsigned p_rob, input bit do_flush, input bit check_rot);
    int unsigned        sel;
    int unsigned        act_unit;
    bit                 has_sel;
    bit                 accept [cdb_pkg::MAX_EU_N];
    cdb_pkg::cdb_data_t exp_item;
    #(DRIVE_DLY);
    flush_i     = do_flush;
    rob_ready_i = ($urandom % 100) < p_rob;
    for (int k = 0; k < cdb_pkg::MAX_EU_N; k++) begin
      eu_valid_i[k]        = ($urandom % 100) < ((k == 0) ? p_max : p_low);
      eu_data_i[k].rob_idx = cdb_pkg::rob_idx_t'(tag_ctr);
      eu_data_i[k].value   = $urandom;
      eu_data_i[k].except  = 1'($urandom);
      if (eu_valid_i[k]) begin
        tag_ctr++;
      end
    end

    // Outputs settle long before mid-cycle
    #(CLK_PERIOD / 2 - DRIVE_DLY);
    if (flush_pending) begin
      check_val({name, "/flush_valid"}, 64'(0), 64'(valid_o));
      flush_pending = 1'b0;
    end
    for (int k = 0; k < cdb_pkg::MAX_EU_N; k++) begin
      check_val($sformatf("%s/eu_ready%0d", name, k),
                64'(model_q[k].size() < cdb_pkg::FIFO_DEPTH), 64'(eu_ready_o[k]));
    end

    // Unit 0 first, then search upward from the pointer with wrap
    has_sel = 1'b0;
    sel     = 0;
    if (model_q[0].size() > 0) begin
      has_sel = 1'b1;
    end else begin
      for (int unsigned i = 0; i < cdb_pkg::LOW_EU_N; i++) begin
        if (!has_sel && model_q[1 + (model_ptr + i) % cdb_pkg::LOW_EU_N].size() > 0) begin
          has_sel = 1'b1;
          sel     = 1 + (model_ptr + i) % cdb_pkg::LOW_EU_N;
        end
      end
    end
    check_val({name, "/valid"}, 64'(has_sel), 64'(valid_o));

    // Head must be on the bus even while the ROB stalls
    if (has_sel) begin
      exp_item = model_q[sel][0];
      check_val({name, "/data"}, 64'(exp_item), 64'(data_o));
    end

    // Unit the DUT actually served, found by matching data_o with each head
    if (has_sel && rob_ready_i && check_rot && sel != 0) begin
      act_unit = 0;
      for (int k = 1; k < cdb_pkg::MAX_EU_N; k++) begin
        if (model_q[k].size() > 0 && model_q[k][0] === data_o) begin
          act_unit = k;
        end
      end
      check_val({name, "/rotation"}, 64'(rot_expect), 64'(act_unit));
      rot_expect = (rot_expect == cdb_pkg::LOW_EU_N) ? 1 : rot_expect + 1;
    end

    // Acceptance uses the fill level before this cycle's pop
    for (int k = 0; k < cdb_pkg::MAX_EU_N; k++) begin
      accept[k] = eu_valid_i[k] && (model_q[k].size() < cdb_pkg::FIFO_DEPTH);
    end
    if (do_flush) begin
      // Everything dropped, pushes of this cycle too
      for (int k = 0; k < cdb_pkg::MAX_EU_N; k++) begin
        model_q[k].delete();
      end
      model_ptr     = 0;
      rot_expect    = 1;
      flush_pending = 1'b1;
    end else begin
      if (has_sel && rob_ready_i) begin
        void'(model_q[sel].pop_front());
        transfers++;
        // Max-priority transfers leave the pointer alone
        if (sel != 0) begin
          model_ptr = sel % cdb_pkg::LOW_EU_N;
        end
      end
      for (int k = 0; k < cdb_pkg::MAX_EU_N; k++) begin
        if (accept[k]) begin
          model_q[k].push_back(eu_data_i[k]);
        end
      end
    end
    @(posedge clk_i);
  endtask

  // Repeat cycles with one traffic profile, probabilities in percent
  task automatic run_phase(input string name, input int unsigned cycles,
                           input int unsigned p_max, input int unsigned p_low,
                           input int unsigned p_rob, input bit check_rot);
    for (int unsigned c = 0; c < cycles; c++) begin
      step(name, p_max, p_low, p_rob, 1'b0, check_rot);
    end
  endtask

  // --------------------------------------------------------------------------
  // Watchdog
  // --------------------------------------------------------------------------

  initial begin
    #(CLK_PERIOD * (TOTAL_CYCLES + MARGIN_CYCLES));
    $display("ERROR: watchdog expired after %0d cycles, the run did not complete",
             TOTAL_CYCLES + MARGIN_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    void'($urandom(SEED));
    errors        = 0;
    checks        = 0;
    transfers     = 0;
    tag_ctr       = 0;
    model_ptr     = 0;
    rot_expect    = 1;
    flush_pending = 1'b0;
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    rob_ready_i   = 1'b0;
    eu_valid_i    = '0;
    eu_data_i     = '0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DLY);
    rst_n_i = 1'b1;

    // Idle bus and free buffers straight out of reset
    #(CLK_PERIOD / 2 - DRIVE_DLY);
    check_val("reset/valid", 64'(0), 64'(valid_o));
    check_val("reset/eu_ready", 64'({cdb_pkg::MAX_EU_N{1'b1}}), 64'(eu_ready_o));
    @(posedge clk_i);

    run_phase("random_mix", MIX_CYCLES, 40, 40, 70, 1'b0);
    run_phase("max_prio", PRIO_CYCLES, 70, 50, 80, 1'b0);

    // ROB stalled, buffers fill and readies drop
    run_phase("back_pressure", STALL_CYCLES, 100, 100, 0, 1'b0);
    run_phase("stall_drain", DRAIN_CYCLES, 0, 0, 100, 1'b0);

    // Load up, flush, then all low units busy so the rotation shows
    run_phase("flush_load", LOAD_CYCLES, 60, 60, 30, 1'b0);
    step("flush", 50, 50, 50, 1'b1, 1'b0);
    run_phase("rotation", ROT_CYCLES, 0, 100, 100, 1'b1);
    run_phase("final_drain", DRAIN_CYCLES, 0, 0, 100, 1'b0);

    for (int k = 0; k < cdb_pkg::MAX_EU_N; k++) begin
      if (model_q[k].size() != 0) begin
        errors++;
        $display("ERROR: unit %0d still holds %0d results that never reached the bus",
                 k, model_q[k].size());
      end
    end

    $display("Checks: %0d, transfers: %0d, errors: %0d", checks, transfers, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
